//--- Bender.yml
# TBI serial PMA wrapper on ref_clk
# Top level tbi_pma_top, testbench tbi_pma_tb

package:
  name: tbi_pma

dependencies: {}

sources:
  # Design sources in compile order, package first
  - files:
      - design/tbi_pma_pkg.sv
      - design/reset_synchronizer.sv
      - design/lvds_reset_sequencer.sv
      - design/lvds_tx_serializer.sv
      - design/lvds_rx_deserializer.sv
      - design/tbi_pma_top.sv

  # Testbench
  - target: test
    files:
      - tests/tbi_pma_tb.sv

//--- design/lvds_reset_sequencer.sv
// -----------------------------------------------
// LVDS receiver bring-up sequence
// PLL reset, lock wait, data realignment reset, one
// channel align pulse, then rx_reset is released
// Lock loss drops back to the lock wait
// -----------------------------------------------

`timescale 1ns/1ps

module lvds_reset_sequencer (
  input  logic ref_clk,
  input  logic reset_ref_clk_int,
  input  logic rx_locked,             // PLL lock, async to ref_clk
  output logic pll_areset,
  output logic rx_cda_reset,          // One cycle pulse
  output logic rx_channel_data_align, // One cycle pulse
  output logic rx_reset
);

  // State codes
  localparam logic [2:0] ST_PLL   = 3'd0; // PLL held in reset
  localparam logic [2:0] ST_WAIT  = 3'd1; // Waiting for synchronized lock
  localparam logic [2:0] ST_CDA   = 3'd2; // Realignment reset
  localparam logic [2:0] ST_ALIGN = 3'd3; // Bit slip pulse
  localparam logic [2:0] ST_RUN   = 3'd4; // Receiver released

  localparam logic [tbi_pma_pkg::SEQ_CNT_WIDTH-1:0] PLL_LAST =
    tbi_pma_pkg::SEQ_CNT_WIDTH'(tbi_pma_pkg::PLL_RESET_CYCLES - 1);

  logic [tbi_pma_pkg::SYNC_DEPTH-1:0]    locked_ff;   // Lock synchronizer
  logic                                  locked_sync;
  logic [2:0]                            state;
  logic [2:0]                            state_nxt;
  logic [tbi_pma_pkg::SEQ_CNT_WIDTH-1:0] seq_cnt;     // PLL reset timer

  // -----------------------------------------------
  // Lock synchronizer
  // -----------------------------------------------

  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      locked_ff <= '0;
    end
    else
    begin
      locked_ff <= {locked_ff[tbi_pma_pkg::SYNC_DEPTH-2:0], rx_locked};
    end
  end

  assign locked_sync = locked_ff[tbi_pma_pkg::SYNC_DEPTH-1];

  // -----------------------------------------------
  // Next state
  // -----------------------------------------------

  always_comb
  begin
    state_nxt = state; // Hold by default
    case (state)
      ST_PLL   : if (seq_cnt == PLL_LAST) state_nxt = ST_WAIT;
      ST_WAIT  : if (locked_sync) state_nxt = ST_CDA;
      ST_CDA   : state_nxt = ST_ALIGN;            // Fixed one cycle spacing
      ST_ALIGN : state_nxt = ST_RUN;
      ST_RUN   : if (!locked_sync) state_nxt = ST_WAIT; // Lock lost, PLL left alone
      default  : state_nxt = ST_PLL;
    endcase
  end

  // State, timer and registered output decode
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      state                 <= ST_PLL;
      seq_cnt               <= '0;
      pll_areset            <= 1'b1;
      rx_cda_reset          <= 1'b0;
      rx_channel_data_align <= 1'b0;
      rx_reset              <= 1'b1;
    end
    else
    begin
      state                 <= state_nxt;
      seq_cnt               <= (state == ST_PLL) ? seq_cnt + 1'b1 : '0; // Runs only in PLL reset
      pll_areset            <= (state_nxt == ST_PLL);
      rx_cda_reset          <= (state_nxt == ST_CDA);
      rx_channel_data_align <= (state_nxt == ST_ALIGN);
      rx_reset              <= (state_nxt != ST_RUN);  // Low only while running
    end
  end

  // Realignment reset and bit slip never overlap
  a_pulses_apart : assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    !(rx_cda_reset && rx_channel_data_align))
    else $error("rx_cda_reset and rx_channel_data_align high together");

  // Receiver release always follows an align pulse
  a_release_after_align : assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $fell(rx_reset) |-> $past(rx_channel_data_align))
    else $error("rx_reset fell without a preceding align pulse");

endmodule

//--- design/lvds_rx_deserializer.sv
// -----------------------------------------------
// TBI receive deserializer
// Collects rxp into code groups once rx_reset is gone
// Realignment reset clears the word counter, align slips it
// First received bit lands in bit 0 of tbi_rx_d
// -----------------------------------------------

`timescale 1ns/1ps

module lvds_rx_deserializer (
  input  logic                              ref_clk,
  input  logic                              reset_ref_clk_int,
  input  logic                              rx_reset,              // Holds the path idle
  input  logic                              rx_cda_reset,          // Clears word position
  input  logic                              rx_channel_data_align, // One bit slip
  input  logic                              rxp,
  output logic [tbi_pma_pkg::TBI_WIDTH-1:0] tbi_rx_d,
  output logic                              tbi_rx_valid
);

  localparam logic [tbi_pma_pkg::BIT_CNT_WIDTH-1:0] LAST_BIT =
    tbi_pma_pkg::BIT_CNT_WIDTH'(tbi_pma_pkg::TBI_WIDTH - 1);

  logic [tbi_pma_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;   // Bits collected so far
  logic                                  bit_adv;   // Counter steps this cycle
  logic                                  word_done; // Tenth bit just went in
  logic [tbi_pma_pkg::TBI_WIDTH-1:0]     rx_shift;  // First bit ends at the top
  logic [tbi_pma_pkg::TBI_WIDTH-1:0]     rx_rev;    // Back to bit 0 first

  assign bit_adv = !rx_reset && !rx_channel_data_align;

  // -----------------------------------------------
  // Word position
  // -----------------------------------------------

  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      bit_cnt   <= '0;
      word_done <= 1'b0;
    end
    else
    begin
      word_done <= bit_adv && (bit_cnt == LAST_BIT);
      if (rx_cda_reset)
        bit_cnt <= '0;                                      // Realignment
      else if (bit_adv)
        bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
    end
  end

  // Shift register in the receiver's own order, top first
  always_ff @(posedge ref_clk)
  begin
    if (!rx_reset)
    begin
      rx_shift <= {rx_shift[tbi_pma_pkg::TBI_WIDTH-2:0], rxp};
    end
  end

  always_comb
  begin
    for (int i = 0; i < tbi_pma_pkg::TBI_WIDTH; i++)
    begin
      rx_rev[i] = rx_shift[tbi_pma_pkg::TBI_WIDTH-1-i];
    end
  end

  // -----------------------------------------------
  // Word output, one cycle after the last bit
  // -----------------------------------------------

  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      tbi_rx_d     <= '0;
      tbi_rx_valid <= 1'b0;
    end
    else
    begin
      tbi_rx_valid <= word_done;
      if (word_done)
        tbi_rx_d <= rx_rev; // Held until the next word
    end
  end

  // Sequencer spacing leaves the counter on a word boundary at release
  a_aligned_at_release : assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $fell(rx_reset) |-> (bit_cnt == '0))
    else $error("Word counter not zero when rx_reset fell");

endmodule

//--- design/lvds_tx_serializer.sv
// -----------------------------------------------
// TBI transmit serializer
// Takes a code group on every word strobe and sends it
// bit 0 first, as Clause 36 asks
// No back-pressure, a word is taken every TBI_WIDTH cycles
// -----------------------------------------------

`timescale 1ns/1ps

module lvds_tx_serializer (
  input  logic                              ref_clk,
  input  logic                              reset_ref_clk_int,
  input  logic [tbi_pma_pkg::TBI_WIDTH-1:0] tbi_tx_d,
  output logic                              tx_word_req, // Sample strobe for tbi_tx_d
  output logic                              txp
);

  localparam logic [tbi_pma_pkg::BIT_CNT_WIDTH-1:0] LAST_BIT =
    tbi_pma_pkg::BIT_CNT_WIDTH'(tbi_pma_pkg::TBI_WIDTH - 1);

  logic [tbi_pma_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;  // Position within the word
  logic [tbi_pma_pkg::TBI_WIDTH-1:0]     tx_rev;   // Word with bit order reversed
  logic [tbi_pma_pkg::TBI_WIDTH-1:0]     tx_shift; // MSB goes out on txp

  // -----------------------------------------------
  // Word timing
  // -----------------------------------------------

  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      bit_cnt <= '0;
    end
    else if (bit_cnt == LAST_BIT)
    begin
      bit_cnt <= '0; // Wrap, next word due
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign tx_word_req = (bit_cnt == '0);

  // -----------------------------------------------
  // Bit reversal and shift out
  // -----------------------------------------------

  // Serializer sends its top bit first, so bit 0 moves to the top
  always_comb
  begin
    for (int i = 0; i < tbi_pma_pkg::TBI_WIDTH; i++)
    begin
      tx_rev[i] = tbi_tx_d[tbi_pma_pkg::TBI_WIDTH-1-i];
    end
  end

  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      tx_shift <= '0; // Line idles low
    end
    else if (tx_word_req)
    begin
      tx_shift <= tx_rev; // Load on the strobe edge
    end
    else
    begin
      tx_shift <= {tx_shift[tbi_pma_pkg::TBI_WIDTH-2:0], 1'b0};
    end
  end

  assign txp = tx_shift[tbi_pma_pkg::TBI_WIDTH-1];

  // Strobes exactly one word apart
  a_strobe_spacing : assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    tx_word_req |=> (!tx_word_req) [* (tbi_pma_pkg::TBI_WIDTH - 1)])
    else $error("tx_word_req repeated within one word time");

endmodule

//--- design/reset_synchronizer.sv
// -----------------------------------------------
// Reset synchronizer for the ref_clk domain
// Raw reset asserts the output at once, release is
// delayed by a chain of flops so it leaves on a clock edge
// -----------------------------------------------

`timescale 1ns/1ps

module reset_synchronizer (
  input  logic ref_clk,
  input  logic reset,             // Raw async reset, active high
  output logic reset_ref_clk_int  // Synchronized release
);

  logic [tbi_pma_pkg::SYNC_DEPTH-1:0] sync_ff; // Release chain

  // Preset on reset, zeros walk in once it is gone
  always_ff @(posedge ref_clk or posedge reset)
  begin
    if (reset)
    begin
      sync_ff <= '1;
    end
    else
    begin
      sync_ff <= {sync_ff[tbi_pma_pkg::SYNC_DEPTH-2:0], 1'b0};
    end
  end

  assign reset_ref_clk_int = sync_ff[tbi_pma_pkg::SYNC_DEPTH-1]; // Last stage drives domain

  // Internal reset must cover every edge the raw reset is active
  a_reset_covers : assert property (@(posedge ref_clk) reset |-> reset_ref_clk_int)
    else $error("reset_ref_clk_int low while reset is high");

endmodule

//--- design/tbi_pma_pkg.sv
// -----------------------------------------------
// Shared constants for the TBI serial PMA wrapper
// Code-group width, serial bit counters, synchronizer
// depth and reset sequencer timing
// Referenced by scoped name from every RTL block
// -----------------------------------------------

package tbi_pma_pkg;

  // -----------------------------------------------
  // Datapath
  // -----------------------------------------------

  localparam int TBI_WIDTH     = 10; // One 8b/10b code group
  localparam int BIT_CNT_WIDTH = 4;  // Holds 0..TBI_WIDTH-1

  // -----------------------------------------------
  // Clock domain crossing
  // -----------------------------------------------

  // Flops in each synchronizer chain, reset and rx_locked alike
  localparam int SYNC_DEPTH = 3;

  // -----------------------------------------------
  // LVDS reset sequencer
  // -----------------------------------------------

  // Cycles pll_areset is held after the internal reset releases
  localparam int PLL_RESET_CYCLES = 8;

  // Sequencer counter width, must cover PLL_RESET_CYCLES-1
  localparam int SEQ_CNT_WIDTH = 4;

endpackage

//--- design/tbi_pma_top.sv
// -----------------------------------------------
// TBI serial PMA top level on ref_clk
// Sits between a ten-bit code-group interface and the
// serial pins, with the LVDS receiver bring-up sequence
// -----------------------------------------------

`timescale 1ns/1ps

module tbi_pma_top (
  input  logic                              ref_clk,
  input  logic                              reset,        // Raw async reset
  input  logic                              rx_locked,    // PLL lock level
  input  logic                              rxp,          // Serial receive bit
  input  logic [tbi_pma_pkg::TBI_WIDTH-1:0] tbi_tx_d,     // Code group to send
  output logic                              txp,          // Serial transmit bit
  output logic                              tx_word_req,  // tbi_tx_d sample strobe
  output logic                              tbi_rx_valid, // New tbi_rx_d
  output logic                              pll_areset,
  output logic                              rx_ready,     // Receiver running
  output logic [tbi_pma_pkg::TBI_WIDTH-1:0] tbi_rx_d      // Received code group
);

  logic reset_ref_clk_int;     // Synchronized reset
  logic rx_cda_reset;
  logic rx_channel_data_align;
  logic rx_reset;

  // -----------------------------------------------
  // Reset and receiver bring-up
  // -----------------------------------------------

  reset_synchronizer u_reset_sync (
    .ref_clk           (ref_clk),
    .reset             (reset),
    .reset_ref_clk_int (reset_ref_clk_int)
  );

  lvds_reset_sequencer u_reset_seq (
    .ref_clk               (ref_clk),
    .reset_ref_clk_int     (reset_ref_clk_int),
    .rx_locked             (rx_locked),
    .pll_areset            (pll_areset),
    .rx_cda_reset          (rx_cda_reset),
    .rx_channel_data_align (rx_channel_data_align),
    .rx_reset              (rx_reset)
  );

  assign rx_ready = ~rx_reset; // Same cycle as the sequencer

  // -----------------------------------------------
  // Serial paths
  // -----------------------------------------------

  lvds_tx_serializer u_tx (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .tbi_tx_d          (tbi_tx_d),
    .tx_word_req       (tx_word_req),
    .txp               (txp)
  );

  lvds_rx_deserializer u_rx (
    .ref_clk               (ref_clk),
    .reset_ref_clk_int     (reset_ref_clk_int),
    .rx_reset              (rx_reset),
    .rx_cda_reset          (rx_cda_reset),
    .rx_channel_data_align (rx_channel_data_align),
    .rxp                   (rxp),
    .tbi_rx_d              (tbi_rx_d),
    .tbi_rx_valid          (tbi_rx_valid)
  );

endmodule

//--- project.f
design/tbi_pma_pkg.sv
design/reset_synchronizer.sv
design/lvds_reset_sequencer.sv
design/lvds_tx_serializer.sv
design/lvds_rx_deserializer.sv
design/tbi_pma_top.sv
tests/tbi_pma_tb.sv

//--- tests/tbi_pma_tb.sv
// --------------------------------------------------
// Testbench for the TBI serial PMA top level
// Checks reset state, LVDS bring-up, TX bit order,
// RX word assembly and recovery after PLL lock loss
// Runs standalone together with the project file list
// --------------------------------------------------

`timescale 1ns/1ps

module tbi_pma_tb;

  localparam int WORDS        = 12;  // RX words checked per phase
  localparam int PLL_TIMEOUT  = 40;  // Cycles allowed for pll_areset release
  localparam int RDY_TIMEOUT  = 20;  // Cycles allowed for rx_ready to move
  localparam int LOSS_CYCLES  = 15;  // rx_locked low time during lock loss

  logic                              ref_clk = 1'b0;
  logic                              reset;
  logic                              rx_locked;
  logic                              rxp;
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] tbi_tx_d;
  logic                              txp;
  logic                              tx_word_req;
  logic                              tbi_rx_valid;
  logic                              pll_areset;
  logic                              rx_ready;
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] tbi_rx_d;

  integer                            seed;
  // TX checker state
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] tx_word;            // Word now on txp
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] tx_next;            // Word sampled at last strobe
  bit                                tx_prev_req = 1'b0; // tx_word_req at the last falling edge
  bit                                tx_run = 1'b0;      // First load done
  int                                tx_idx = 0;
  int                                tx_gap = 0;
  // RX stimulus and checker state
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] rx_hist;            // Sent bits with the oldest at the top
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] rx_expect[$];
  logic [tbi_pma_pkg::TBI_WIDTH-1:0] rx_exp_word;
  logic                              rx_bit;
  int                                rx_idx = 0;
  int                                rx_checked = 0;

  tbi_pma_top uut (
    .ref_clk      (ref_clk),
    .reset        (reset),
    .rx_locked    (rx_locked),
    .rxp          (rxp),
    .tbi_tx_d     (tbi_tx_d),
    .txp          (txp),
    .tx_word_req  (tx_word_req),
    .tbi_rx_valid (tbi_rx_valid),
    .pll_areset   (pll_areset),
    .rx_ready     (rx_ready),
    .tbi_rx_d     (tbi_rx_d)
  );

  always #5 ref_clk = ~ref_clk; // 10 ns period

  // --------------------------------------------------
  // Reference model and error reporting
  // --------------------------------------------------

  // Bit idx of the code group goes out idx cycles after the strobe (Clause 36 order)
  function automatic logic tx_bit_ref(input logic [tbi_pma_pkg::TBI_WIDTH-1:0] word,
                                      input int idx);
    return word[idx];
  endfunction

  // First sent bit sits at the top of the history and becomes bit 0
  function automatic logic [tbi_pma_pkg::TBI_WIDTH-1:0] rx_word_ref(
    input logic [tbi_pma_pkg::TBI_WIDTH-1:0] hist);
    logic [tbi_pma_pkg::TBI_WIDTH-1:0] word;
    for (int i = 0; i < tbi_pma_pkg::TBI_WIDTH; i++)
    begin
      word[i] = hist[tbi_pma_pkg::TBI_WIDTH-1-i];
    end
    return word;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    stop_with_error($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  task automatic check_reset_state();
    assert (pll_areset === 1'b1) else value_mismatch("pll_areset", 1, pll_areset);
    assert (rx_ready === 1'b0) else value_mismatch("rx_ready", 0, rx_ready);
    assert (txp === 1'b0) else value_mismatch("txp", 0, txp);
    assert (tbi_rx_valid === 1'b0) else value_mismatch("tbi_rx_valid", 0, tbi_rx_valid);
    assert (tbi_rx_d === '0) else value_mismatch("tbi_rx_d", 0, tbi_rx_d);
  endtask

  // Polled on rising edges while rx_checked moves on falling ones
  task automatic wait_for_words(input int count);
    int target;
    int cycles;
    target = rx_checked + count;
    cycles = 0;
    while (rx_checked < target)
    begin
      @(posedge ref_clk);
      cycles++;
      assert (cycles <= count * tbi_pma_pkg::TBI_WIDTH + 40)
        else stop_with_error("Timed out waiting for received words on tbi_rx_valid");
    end
  endtask

  // --------------------------------------------------
  // Stimulus 1 ns after each rising edge
  // --------------------------------------------------

  always @(posedge ref_clk)
  begin
    #1;
    if (tx_prev_req)
      tbi_tx_d = $random(seed); // Fresh word after every strobe
    if (rx_ready)
    begin
      rx_bit  = $random(seed);
      rxp     = rx_bit;
      rx_hist = {rx_hist[tbi_pma_pkg::TBI_WIDTH-2:0], rx_bit};
      if (rx_idx == tbi_pma_pkg::TBI_WIDTH - 1)
      begin
        assert (rx_expect.size() == 0)
          else stop_with_error("Previous received word never produced tbi_rx_valid");
        rx_expect.push_back(rx_word_ref(rx_hist));
        rx_idx = 0;
      end
      else
        rx_idx++;
    end
    else
    begin
      rxp    = $random(seed); // Line noise while receiver is held
      rx_idx = 0;             // Partial word dropped
    end
  end

  // --------------------------------------------------
  // Comparing processes sampled on falling edges
  // --------------------------------------------------

  always @(negedge ref_clk)
  begin
    if (tx_prev_req)
    begin
      tx_word = tx_next; // Loaded on the edge just passed
      tx_idx  = 0;
    end
    if (!tx_word_req && !reset)
      tx_run = 1'b1;
    if (tx_run)
    begin
      assert (tx_idx < tbi_pma_pkg::TBI_WIDTH)
        else stop_with_error("txp ran past a code group with no new tx_word_req");
      assert (txp === tx_bit_ref(tx_word, tx_idx))
        else value_mismatch("txp", tx_bit_ref(tx_word, tx_idx), txp);
      tx_idx++;
    end
    tx_gap++;
    if (tx_word_req)
    begin
      if (tx_run)
      begin
        assert (tx_gap == tbi_pma_pkg::TBI_WIDTH)
          else value_mismatch("tx_word_req spacing", tbi_pma_pkg::TBI_WIDTH, tx_gap);
      end
      tx_gap  = 0;
      tx_next = tbi_tx_d;
    end
    tx_prev_req = tx_word_req;
  end

  always @(negedge ref_clk)
  begin
    if (tbi_rx_valid === 1'b1)
    begin
      assert (rx_expect.size() > 0)
        else stop_with_error("tbi_rx_valid pulsed with no complete word sent on rxp");
      rx_exp_word = rx_expect.pop_front();
      assert (tbi_rx_d === rx_exp_word) else value_mismatch("tbi_rx_d", rx_exp_word, tbi_rx_d);
      rx_checked++;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial
  begin
    int cycles;
    int lock_delay;
    int skew;
    seed      = 81265;
    reset     = 1'b1;
    rx_locked = 1'b0;
    rxp       = 1'b0;
    tbi_tx_d  = '0;

    // Reset state and PLL reset hold
    @(negedge ref_clk);
    check_reset_state();
    @(posedge ref_clk);
    #1 reset = 1'b0;   // Two cycles of reset
    @(negedge ref_clk);
    check_reset_state(); // Internal reset still held
    cycles = 0;
    while (pll_areset === 1'b1)
    begin
      cycles++;
      assert (cycles <= PLL_TIMEOUT) else stop_with_error("pll_areset was never released");
      @(negedge ref_clk);
    end
    assert (cycles >= tbi_pma_pkg::PLL_RESET_CYCLES)
      else value_mismatch("pll_areset hold cycles", tbi_pma_pkg::PLL_RESET_CYCLES, cycles);

    // Receiver stays held during the lock wait
    lock_delay = 20 + ($unsigned($random(seed)) % 41);
    repeat (lock_delay)
    begin
      @(negedge ref_clk);
      assert (rx_ready === 1'b0) else value_mismatch("rx_ready", 0, rx_ready);
    end
    @(posedge ref_clk);
    #1 rx_locked = 1'b1;
    cycles = 0;
    while (rx_ready !== 1'b1)
    begin
      @(negedge ref_clk);
      cycles++;
      assert (cycles <= RDY_TIMEOUT) else stop_with_error("rx_ready did not rise after lock");
    end
    wait_for_words(WORDS);

    // Lock loss at a random point inside a word
    skew = $unsigned($random(seed)) % tbi_pma_pkg::TBI_WIDTH;
    repeat (skew) @(posedge ref_clk);
    #1 rx_locked = 1'b0;
    cycles = 0;
    while (rx_ready !== 1'b0)
    begin
      @(negedge ref_clk);
      cycles++;
      assert (cycles <= RDY_TIMEOUT) else stop_with_error("rx_ready did not fall on lock loss");
    end
    for (int i = 0; i < LOSS_CYCLES; i++)
    begin
      @(negedge ref_clk);
      assert (rx_ready === 1'b0) else value_mismatch("rx_ready", 0, rx_ready);
      if (i >= 1)   // A word ending on the fall edge may still report
      begin
        assert (tbi_rx_valid === 1'b0) else value_mismatch("tbi_rx_valid", 0, tbi_rx_valid);
      end
    end
    @(posedge ref_clk);
    #1 rx_locked = 1'b1;
    cycles = 0;
    while (rx_ready !== 1'b1)
    begin
      @(negedge ref_clk);
      cycles++;
      assert (cycles <= RDY_TIMEOUT) else stop_with_error("rx_ready did not return after relock");
    end
    wait_for_words(WORDS);

    $display("TEST OK");
    $finish;
  end

endmodule
